/* rtl/stream_pkg.sv */
// Beat widths and the tagged beat word shared by every stage of the stream merge datapath.
package stream_pkg;

    // payload width of one beat in bits.
    localparam int data_w = 16;

    // width of the source id that rides along with every beat.
    localparam int id_w = 4;

    // total width of one tagged word as it moves between the stages.
    localparam int beat_w = id_w + data_w;

    // the id sits in the upper bits and the data in the lower bits.
    // this order matches the {id, data} concatenation of the interconnect word.
    typedef struct packed {
        logic [id_w-1:0]   id;   // source id captured when the beat entered its port.
        logic [data_w-1:0] data; // payload exactly as the source offered it.
    } tagged_beat_t;

endpackage

/* rtl/route_pkg.sv */
// Port count, path address width and path state encoding used by the path switch and the top level.
package route_pkg;

    // number of source ports feeding the merge.
    localparam int num_ports = 4;

    // width of the forced path address.
    localparam int addr_w = $clog2(num_ports);

    // state of the input path.
    // the switch leaves path_closed on the first forced address and never returns before reset.
    typedef enum logic {
        path_closed = 1'b0, // no address forced since reset, so every port is blocked.
        path_open   = 1'b1  // an address is in force and its port is merged downstream.
    } path_state_e;

endpackage

/* rtl/ingress_slice.sv */
// One-beat input register per source port; tags each accepted beat with the port's id.
`timescale 1ns/1ps
module ingress_slice (
    input  logic                         clock,   // rising edge clock of the whole merge.
    input  logic                         arst_n,  // asynchronous reset, active low.
    input  logic                         s_valid, // source offers a beat.
    input  logic [stream_pkg::data_w-1:0] s_data, // source payload.
    input  logic [stream_pkg::id_w-1:0]   sid,    // id of this port, sampled with each beat.
    output logic                         s_ready, // slice can take a beat on this edge.
    output logic                         t_valid, // slice holds a tagged beat.
    output stream_pkg::tagged_beat_t     t_beat,  // the held tagged beat.
    input  logic                         t_ready  // path switch takes the held beat.
);

    logic                     full;     // the single entry holds a beat.
    stream_pkg::tagged_beat_t beat_q;   // payload register of the entry.
    logic                     s_fire;   // a source beat transfers on this edge.
    logic                     t_fire;   // the held beat leaves on this edge.

    assign t_fire  = full & t_ready;          // only a full slice can hand a beat on.
    assign s_ready = ~full | t_ready;         // room now, or room made by the leaving beat.
    assign s_fire  = s_valid & s_ready;       // handshake on the source side.

    // the full flag follows the two handshakes.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;                     // empty after reset.
        end else if (s_fire) begin
            full <= 1'b1;                     // a new beat fills the entry, even when one leaves.
        end else if (t_fire) begin
            full <= 1'b0;                     // the last beat left and nothing replaced it.
        end
    end

    // the id is captured together with the data.
    // a later change on sid therefore never alters a beat already inside.
    always_ff @(posedge clock) begin
        if (s_fire) begin
            beat_q.id   <= sid;               // tag with the port id at acceptance.
            beat_q.data <= s_data;            // payload stays stable until the beat leaves.
        end
    end

    assign t_valid = full;                    // valid exactly while the entry is occupied.
    assign t_beat  = beat_q;                  // word is held stable until t_fire.

endmodule

/* rtl/path_switch.sv */
// Forced-address path switch; merges the beat of the open port and steers downstream ready back to it.
`timescale 1ns/1ps
module path_switch (
    input  logic                           clock,    // rising edge clock.
    input  logic                           arst_n,   // asynchronous reset, active low.
    input  logic [route_pkg::addr_w-1:0]   addr,     // address to force on the next addr_vld.
    input  logic                           addr_vld, // strobe that loads addr on this edge.
    output logic [route_pkg::addr_w-1:0]   curr_addr, // address currently in force.
    input  logic                           t_valid [route_pkg::num_ports-1:0], // slice valids.
    input  stream_pkg::tagged_beat_t       t_beat  [route_pkg::num_ports-1:0], // slice beats.
    output logic                           t_ready [route_pkg::num_ports-1:0], // slice readys.
    output logic                           o_valid,  // merged beat towards the egress buffer.
    output stream_pkg::tagged_beat_t       o_beat,   // merged tagged word.
    input  logic                           o_ready   // egress buffer takes the merged beat.
);

    route_pkg::path_state_e             state;      // closed until the first forced address.
    logic [route_pkg::addr_w-1:0]       addr_q;     // forced address register.
    logic                               path_on;    // the path is open this cycle.
    logic                               sel_valid;  // valid of the slice at the open address.

    // the address register and the state move together on addr_vld.
    // the path may be switched between any two beats because a beat only leaves its
    // slice on a handshake, and unselected slices simply keep holding theirs.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state  <= route_pkg::path_closed;       // no port is open after reset.
            addr_q <= '0;                           // curr_addr reads zero after reset.
        end else if (addr_vld) begin
            state  <= route_pkg::path_open;         // the first strobe opens the path for good.
            addr_q <= addr;                         // new address in force from this edge on.
        end
    end

    assign curr_addr = addr_q;                      // registered address drives the selection.
    assign path_on   = (state == route_pkg::path_open);

    // selection of the open port is purely combinational.
    assign sel_valid = t_valid[addr_q];             // valid of the addressed slice.
    assign o_valid   = path_on & sel_valid;         // nothing passes while the path is closed.
    assign o_beat    = t_beat[addr_q];              // word is only qualified by o_valid.

    // downstream ready goes back to the addressed slice alone.
    // every other slice sees ready low and keeps its beat in order.
    always_comb begin
        for (int i = 0; i < route_pkg::num_ports; i++) begin
            t_ready[i] = path_on & o_ready & (int'(addr_q) == i); // one ready at most.
        end
    end

endmodule

/* rtl/egress_buffer.sv */
// Two-entry output queue that cuts the ready path and splits the tagged word into id and data.
`timescale 1ns/1ps
module egress_buffer (
    input  logic                          clock,   // rising edge clock.
    input  logic                          arst_n,  // asynchronous reset, active low.
    input  logic                          i_valid, // merged beat offered by the path switch.
    input  stream_pkg::tagged_beat_t      i_beat,  // merged tagged word.
    output logic                          i_ready, // buffer has a free entry.
    output logic                          m_valid, // head beat is presented.
    output logic [stream_pkg::id_w-1:0]   m_id,    // source id of the head beat.
    output logic [stream_pkg::data_w-1:0] m_data,  // payload of the head beat.
    input  logic                          m_ready  // sink takes the head beat.
);

    stream_pkg::tagged_beat_t mem [2];   // the two storage entries.
    logic                     wr_ptr;    // entry written by the next accepted beat.
    logic                     rd_ptr;    // entry holding the head beat.
    logic [1:0]               count;     // number of occupied entries, zero to two.
    logic                     push;      // an upstream beat enters on this edge.
    logic                     pop;       // the head beat leaves on this edge.
    stream_pkg::tagged_beat_t head;      // head entry seen at the output.

    // ready depends on the count register only.
    // m_ready therefore never reaches the sources combinationally.
    assign i_ready = (count != 2'd2);               // room while fewer than two are used.
    assign m_valid = (count != 2'd0);               // any stored beat is presented.
    assign push    = i_valid & i_ready;             // upstream handshake.
    assign pop     = m_valid & m_ready;             // downstream handshake.

    // pointers and count are the control state of the queue.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= 1'b0;                         // both pointers start at entry zero.
            rd_ptr <= 1'b0;
            count  <= 2'd0;                         // empty after reset.
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;                  // two entries, so the pointer just flips.
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;                  // next entry becomes the head.
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;     // fill only.
                2'b01:   count <= count - 2'd1;     // drain only.
                default: count <= count;            // both or neither keep the level.
            endcase
        end
    end

    // storage is written on every accepted beat.
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= i_beat;                  // the free entry takes the new beat.
        end
    end

    assign head   = mem[rd_ptr];                    // stays stable while m_ready is low.
    assign m_id   = head.id;                        // id field on its own port.
    assign m_data = head.data;                      // data field on its own port.

endmodule

/* rtl/stream_merge_top.sv */
// Top level of the stream merge; chains the per-port ingress slices, the path switch and the egress buffer.
`timescale 1ns/1ps
module stream_merge_top (
    input  logic                          clock,    // rising edge clock.
    input  logic                          arst_n,   // asynchronous reset, active low.
    input  logic                          s_valid [route_pkg::num_ports-1:0], // source valids.
    input  logic [stream_pkg::data_w-1:0] s_data  [route_pkg::num_ports-1:0], // source payloads.
    output logic                          s_ready [route_pkg::num_ports-1:0], // source readys.
    input  logic [stream_pkg::id_w-1:0]   sid     [route_pkg::num_ports-1:0], // per-port ids.
    input  logic [route_pkg::addr_w-1:0]  addr,     // path address to force.
    input  logic                          addr_vld, // strobe that forces addr.
    output logic [route_pkg::addr_w-1:0]  curr_addr, // path address in force.
    output logic                          m_valid,  // output beat valid.
    output logic [stream_pkg::data_w-1:0] m_data,   // output payload.
    output logic [stream_pkg::id_w-1:0]   m_id,     // source id of the output beat.
    input  logic                          m_ready   // sink ready.
);

    logic                     t_valid [route_pkg::num_ports-1:0]; // slice to switch valids.
    stream_pkg::tagged_beat_t t_beat  [route_pkg::num_ports-1:0]; // slice to switch words.
    logic                     t_ready [route_pkg::num_ports-1:0]; // switch to slice readys.
    logic                     o_valid;  // switch to buffer valid.
    stream_pkg::tagged_beat_t o_beat;   // switch to buffer word.
    logic                     o_ready;  // buffer to switch ready.

    // one register slice per source port.
    for (genvar i = 0; i < route_pkg::num_ports; i++) begin : g_ingress
        ingress_slice ingress_slice_i (
            .clock   (clock),
            .arst_n  (arst_n),
            .s_valid (s_valid[i]),
            .s_data  (s_data[i]),
            .sid     (sid[i]),
            .s_ready (s_ready[i]),
            .t_valid (t_valid[i]),
            .t_beat  (t_beat[i]),
            .t_ready (t_ready[i])
        );
    end

    path_switch path_switch_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .addr      (addr),
        .addr_vld  (addr_vld),
        .curr_addr (curr_addr),
        .t_valid   (t_valid),
        .t_beat    (t_beat),
        .t_ready   (t_ready),
        .o_valid   (o_valid),
        .o_beat    (o_beat),
        .o_ready   (o_ready)
    );

    egress_buffer egress_buffer_i (
        .clock   (clock),
        .arst_n  (arst_n),
        .i_valid (o_valid),
        .i_beat  (o_beat),
        .i_ready (o_ready),
        .m_valid (m_valid),
        .m_id    (m_id),
        .m_data  (m_data),
        .m_ready (m_ready)
    );

endmodule

/* verif/stream_merge_table.svh */
// Stimulus steps of the stream merge testbench; included inside the testbench module.

// columns: addr_vld, addr, s_valid mask (ports 3..0), m_ready mode (0 low, 1 high, 2 random), hold.
localparam int num_steps = 19;                    // rows in the step table.

step_t                       steps   [num_steps];            // the step table itself.
logic [stream_pkg::id_w-1:0] port_id [route_pkg::num_ports]; // fixed sid of every port.

task automatic load_table();
    port_id[0] = 4'h3;                              // ids are distinct so a wrong tag shows up.
    port_id[1] = 4'h7;
    port_id[2] = 4'ha;
    port_id[3] = 4'hc;
    steps[0]  = {1'b0, 2'd0, 4'b1111, 2'd1, 8'd5};  // path closed, each port fills its slice.
    steps[1]  = {1'b1, 2'd0, 4'b0001, 2'd1, 8'd12}; // stream port 0 at full rate.
    steps[2]  = {1'b1, 2'd1, 4'b0011, 2'd1, 8'd10}; // port 0 keeps offering but must wait.
    steps[3]  = {1'b1, 2'd2, 4'b0101, 2'd1, 8'd8};
    steps[4]  = {1'b1, 2'd0, 4'b0001, 2'd1, 8'd8};  // the waiting port 0 beats come out now.
    steps[5]  = {1'b1, 2'd3, 4'b1000, 2'd2, 8'd16}; // random back-pressure on one port.
    steps[6]  = {1'b1, 2'd1, 4'b1111, 2'd2, 8'd16};
    steps[7]  = {1'b1, 2'd2, 4'b1111, 2'd0, 8'd6};  // sink stalls, so the buffer fills up.
    steps[8]  = {1'b0, 2'd0, 4'b1111, 2'd2, 8'd12};
    steps[9]  = {1'b1, 2'd0, 4'b1111, 2'd1, 8'd3};  // fast switching between beats.
    steps[10] = {1'b1, 2'd3, 4'b1111, 2'd1, 8'd3};
    steps[11] = {1'b1, 2'd1, 4'b1111, 2'd2, 8'd3};
    steps[12] = {1'b1, 2'd2, 4'b1111, 2'd1, 8'd2};
    steps[13] = {1'b1, 2'd0, 4'b1111, 2'd2, 8'd4};
    steps[14] = {1'b1, 2'd0, 4'b0000, 2'd1, 8'd6};  // drain every port in turn.
    steps[15] = {1'b1, 2'd1, 4'b0000, 2'd1, 8'd6};
    steps[16] = {1'b1, 2'd2, 4'b0000, 2'd1, 8'd6};
    steps[17] = {1'b1, 2'd3, 4'b0000, 2'd1, 8'd6};
    steps[18] = {1'b0, 2'd0, 4'b0000, 2'd1, 8'd4};  // let the egress buffer empty out.
endtask

/* verif/stream_merge_tb.sv */
// Testbench for the stream merge top level; runs the step table and checks against a port model.
`timescale 1ns/1ps
module stream_merge_tb;

    // one row of the stimulus table.
    typedef struct packed {
        logic                            addr_vld;   // force addr in the first cycle of the step.
        logic [route_pkg::addr_w-1:0]    addr;       // address to force.
        logic [route_pkg::num_ports-1:0] valid_mask; // ports that keep offering beats.
        logic [1:0]                      ready_mode; // 0 low, 1 high, 2 random.
        logic [7:0]                      hold;       // length of the step in cycles.
    } step_t;

    logic                          clock;
    logic                          arst_n;
    logic                          s_valid [route_pkg::num_ports-1:0];
    logic [stream_pkg::data_w-1:0] s_data  [route_pkg::num_ports-1:0];
    logic                          s_ready [route_pkg::num_ports-1:0];
    logic [stream_pkg::id_w-1:0]   sid     [route_pkg::num_ports-1:0];
    logic [route_pkg::addr_w-1:0]  addr;
    logic                          addr_vld;
    logic [route_pkg::addr_w-1:0]  curr_addr;
    logic                          m_valid;
    logic [stream_pkg::data_w-1:0] m_data;
    logic [stream_pkg::id_w-1:0]   m_id;
    logic                          m_ready;

    integer seed;        // state of $random.
    int     limit;       // cycle budget of the whole run.
    int     cycle_count; // cycles seen since time zero.

    logic                         pending  [route_pkg::num_ports]; // a source beat is on offer.
    logic                         src_fire [route_pkg::num_ports]; // it transfers on the next edge.
    logic                         model_open;  // model of the path state.
    logic [route_pkg::addr_w-1:0] model_addr;  // model of the address in force.
    logic                         held_vld [route_pkg::num_ports]; // model slice is full.
    stream_pkg::tagged_beat_t     held     [route_pkg::num_ports]; // beat held in the slice.
    stream_pkg::tagged_beat_t     out_q [$];   // beats inside the egress buffer, head first.

    `include "stream_merge_table.svh"

    stream_merge_top stream_merge_top_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .s_valid   (s_valid),
        .s_data    (s_data),
        .s_ready   (s_ready),
        .sid       (sid),
        .addr      (addr),
        .addr_vld  (addr_vld),
        .curr_addr (curr_addr),
        .m_valid   (m_valid),
        .m_data    (m_data),
        .m_id      (m_id),
        .m_ready   (m_ready)
    );

    always #4 clock = ~clock;                       // 8 ns period.

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_beat(input stream_pkg::tagged_beat_t got,
                              input stream_pkg::tagged_beat_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: output id %h data %h, expected id %h data %h",
                                     $time, got.id, got.data, exp.id, exp.data));
        end
    endtask

    task automatic check_addr(input logic [route_pkg::addr_w-1:0] got,
                              input logic [route_pkg::addr_w-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: curr_addr is %0d, expected %0d",
                                     $time, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s is %b, expected %b",
                                     $time, what, got, exp));
        end
    endtask

    // one cycle of stimulus, called right after a rising edge.
    task automatic drive_cycle(input step_t st, input bit first);
        int          p;
        logic [31:0] r;
        addr_vld <= first & st.addr_vld;            // strobe lasts one cycle.
        if (first) begin
            addr <= st.addr;
        end
        case (st.ready_mode)
            2'd0:    m_ready <= 1'b0;
            2'd1:    m_ready <= 1'b1;
            default: begin
                r = $random(seed);
                m_ready <= r[0];                    // coin flip per cycle.
            end
        endcase
        for (p = 0; p < route_pkg::num_ports; p++) begin
            // an offered beat stays put until it has transferred.
            if (!pending[p] || src_fire[p]) begin
                if (st.valid_mask[p]) begin
                    r = $random(seed);
                    s_valid[p] <= 1'b1;
                    s_data[p]  <= r[stream_pkg::data_w-1:0];
                    pending[p] = 1'b1;
                end else begin
                    s_valid[p] <= 1'b0;
                    pending[p] = 1'b0;
                end
            end
        end
    endtask

    // true while any beat is still offered, held in a slice or buffered.
    function automatic bit model_busy();
        bit busy;
        int p;
        busy = (out_q.size() != 0);
        for (p = 0; p < route_pkg::num_ports; p++) begin
            busy = busy | held_vld[p] | pending[p];
        end
        return busy;
    endfunction

    // the monitor samples at the falling edge, where every level is settled.
    // what it sees there is exactly what the next rising edge will act on.
    always @(negedge clock) begin : monitor
        logic                     sel;
        logic                     exp_ready;
        stream_pkg::tagged_beat_t got;
        int                       p;
        if (arst_n) begin
            check_addr(curr_addr, model_addr);      // address register after the last edge.
            check_bit(m_valid, out_q.size() != 0, "m_valid");
            got = {m_id, m_data};
            if (out_q.size() != 0) begin
                check_beat(got, out_q[0]);          // also holds the head stable under a stall.
            end
            // a beat crosses the switch when its path is open and the buffer has room.
            sel = model_open && held_vld[model_addr] && (out_q.size() < 2);
            for (p = 0; p < route_pkg::num_ports; p++) begin
                exp_ready = !held_vld[p] || (sel && int'(model_addr) == p);
                check_bit(s_ready[p], exp_ready, $sformatf("s_ready[%0d]", p));
                src_fire[p] = s_valid[p] && s_ready[p];
            end
            if (m_valid && m_ready) begin
                void'(out_q.pop_front());           // head leaves before a new beat lands.
            end
            if (sel) begin
                out_q.push_back(held[model_addr]);  // selected under the address now in force.
                held_vld[model_addr] = 1'b0;
            end
            for (p = 0; p < route_pkg::num_ports; p++) begin
                if (src_fire[p]) begin
                    held[p]     = {port_id[p], s_data[p]};
                    held_vld[p] = 1'b1;
                end
            end
            if (addr_vld) begin
                model_open = 1'b1;                  // the path never closes again.
                model_addr = addr;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > limit) begin
            report_failure($sformatf("timeout after %0d cycles, the output never drained",
                                     cycle_count));
        end
    end

    initial begin : stimulus
        int    s;
        int    c;
        int    p;
        step_t idle_step;
        seed        = 32'h575eaa24;
        cycle_count = 0;
        load_table();
        limit = 50;                                 // slack for reset and the final drain.
        for (s = 0; s < num_steps; s++) begin
            limit += steps[s].hold;
        end
        idle_step   = {1'b0, 2'd0, 4'b0000, 2'd1, 8'd1};
        clock       = 1'b0;
        arst_n      = 1'b0;
        addr        = '0;
        addr_vld    = 1'b0;
        m_ready     = 1'b0;
        model_open  = 1'b0;
        model_addr  = '0;
        for (p = 0; p < route_pkg::num_ports; p++) begin
            s_valid[p]  = 1'b0;
            s_data[p]   = '0;
            sid[p]      = port_id[p];               // ids stay fixed for the whole run.
            pending[p]  = 1'b0;
            src_fire[p] = 1'b0;
            held_vld[p] = 1'b0;
            held[p]     = '0;
        end
        repeat (2) @(posedge clock);
        arst_n <= 1'b1;
        for (s = 0; s < num_steps; s++) begin
            for (c = 0; c < steps[s].hold; c++) begin
                @(posedge clock);
                drive_cycle(steps[s], c == 0);
            end
        end
        // the timeout bounds this wait.
        while (model_busy()) begin
            @(posedge clock);
            drive_cycle(idle_step, 1'b0);
        end
        // one more falling edge sees the output empty after the last beat left.
        @(posedge clock);
        $display("Done: no errors");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verif
rtl/stream_pkg.sv
rtl/route_pkg.sv
rtl/ingress_slice.sv
rtl/path_switch.sv
rtl/egress_buffer.sv
rtl/stream_merge_top.sv
verif/stream_merge_tb.sv
